// File: logic/axi_bank_pkg.sv
// Shared widths, vector types, response code and response-kind enum of the bank bridge
package axi_bank_pkg;

  // Byte address width
  localparam int unsigned ADDR_WIDTH = 16;
  // Full AXI data word
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned ID_WIDTH = 4;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  typedef logic [ID_WIDTH-1:0] id_t;
  typedef logic [1:0] resp_t;

  // Every access completes with OKAY
  localparam resp_t RESP_OKAY = 2'b00;

  // Channel that a memory access answers on
  typedef enum logic {
    RESP_READ,
    RESP_WRITE
  } resp_kind_t;

endpackage

// File: logic/req_decoder.sv
// Request decoder: write/read acceptance, word alignment and per-bank slicing
`timescale 1ns/1ps

module req_decoder #(
  parameter int unsigned NumBanks = 4,
  localparam int unsigned BankBits = axi_bank_pkg::DATA_WIDTH / NumBanks,
  localparam int unsigned BankBytes = BankBits / 8
) (
  input  logic                                aw_valid_i,
  output logic                                aw_ready_o,
  input  axi_bank_pkg::addr_t                 aw_addr_i,
  input  logic                                w_valid_i,
  output logic                                w_ready_o,
  input  axi_bank_pkg::data_t                 w_data_i,
  input  axi_bank_pkg::strb_t                 w_strb_i,
  input  logic                                ar_valid_i,
  output logic                                ar_ready_o,
  input  axi_bank_pkg::addr_t                 ar_addr_i,
  input  axi_bank_pkg::id_t                   ar_id_i,
  input  logic [NumBanks-1:0]                 req_ready_i,
  input  logic [NumBanks-1:0]                 resp_ready_i,
  input  logic                                kind_full_i,
  input  logic                                b_ready_i,
  input  logic                                r_ready_i,
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output axi_bank_pkg::addr_t [NumBanks-1:0]  bank_addr_o,
  output logic [NumBanks-1:0][BankBits-1:0]   bank_wdata_o,
  output logic [NumBanks-1:0][BankBytes-1:0]  bank_strb_o,
  output logic                                kind_push_o,
  output axi_bank_pkg::resp_kind_t            kind_o,
  output logic                                b_trigger_o,
  output logic                                r_trigger_o,
  output axi_bank_pkg::id_t                   r_id_o,
  output logic                                busy_o
);

  localparam int unsigned WordBytes = axi_bank_pkg::DATA_WIDTH / 8;

  logic                 room;
  logic                 write_req;
  logic                 do_write;
  logic                 do_read;
  axi_bank_pkg::addr_t  req_addr;
  axi_bank_pkg::addr_t  word_addr;

  // Every bank register and the order FIFO take the access together
  assign room = (&req_ready_i) & (&resp_ready_i) & ~kind_full_i;

  // Writes win over reads
  assign write_req = aw_valid_i & w_valid_i & b_ready_i;
  assign do_write  = write_req & room;
  assign do_read   = ~write_req & ar_valid_i & r_ready_i & room;

  assign aw_ready_o = do_write;
  assign w_ready_o  = do_write;
  assign ar_ready_o = do_read;

  assign mem_req_o   = do_write | do_read;
  assign mem_we_o    = do_write;
  assign kind_push_o = do_write | do_read;
  assign kind_o      = do_write ? axi_bank_pkg::RESP_WRITE : axi_bank_pkg::RESP_READ;
  assign b_trigger_o = do_write;
  assign r_trigger_o = do_read;
  assign r_id_o      = ar_id_i;

  // Clear the byte offset within the full word
  assign req_addr  = do_write ? aw_addr_i : ar_addr_i;
  assign word_addr = req_addr & ~axi_bank_pkg::addr_t'(WordBytes - 1);

  for (genvar i = 0; i < NumBanks; i++) begin : gen_slices
    assign bank_addr_o[i]  = word_addr + axi_bank_pkg::addr_t'(i * BankBytes);
    assign bank_wdata_o[i] = w_data_i[i*BankBits +: BankBits];
    assign bank_strb_o[i]  = w_strb_i[i*BankBytes +: BankBytes];
  end

  assign busy_o = aw_valid_i | ar_valid_i | ~b_ready_i | ~r_ready_i;

endmodule

// File: logic/bank_port.sv
// Per-bank fall-through request register and fall-through response register
`timescale 1ns/1ps

module bank_port #(
  parameter int unsigned NumBanks = 4,
  localparam int unsigned BankBits = axi_bank_pkg::DATA_WIDTH / NumBanks,
  localparam int unsigned BankBytes = BankBits / 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // From the request decoder
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  axi_bank_pkg::addr_t   addr_i,
  input  logic [BankBits-1:0]   wdata_i,
  input  logic [BankBytes-1:0]  strb_i,
  input  logic                  we_i,
  // Memory bank
  output logic                  bank_req_o,
  input  logic                  bank_gnt_i,
  output axi_bank_pkg::addr_t   bank_addr_o,
  output logic [BankBits-1:0]   bank_wdata_o,
  output logic [BankBytes-1:0]  bank_strb_o,
  output logic                  bank_we_o,
  input  logic                  bank_rvalid_i,
  input  logic [BankBits-1:0]   bank_rdata_i,
  // To the response join
  output logic                  resp_valid_o,
  output logic [BankBits-1:0]   resp_data_o,
  input  logic                  resp_pop_i
);

  logic                 req_full_q;
  axi_bank_pkg::addr_t  addr_q;
  logic [BankBits-1:0]  wdata_q;
  logic [BankBytes-1:0] strb_q;
  logic                 we_q;
  logic                 resp_full_q;
  logic                 resp_load;
  logic [BankBits-1:0]  rdata_q;

  // Request passes straight to the bank while the register is empty
  assign req_ready_o  = ~req_full_q;
  assign bank_req_o   = req_full_q | req_valid_i;
  assign bank_addr_o  = req_full_q ? addr_q  : addr_i;
  assign bank_wdata_o = req_full_q ? wdata_q : wdata_i;
  assign bank_strb_o  = req_full_q ? strb_q  : strb_i;
  assign bank_we_o    = req_full_q ? we_q    : we_i;

  // Same for the response, stored only when it cannot leave this cycle
  assign resp_valid_o = resp_full_q | bank_rvalid_i;
  assign resp_data_o  = resp_full_q ? rdata_q : bank_rdata_i;
  assign resp_load    = bank_rvalid_i & (resp_full_q == resp_pop_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_full_q  <= 1'b0;
      resp_full_q <= 1'b0;
    end else begin
      if (req_full_q) begin
        req_full_q <= ~bank_gnt_i;
      end else begin
        req_full_q <= req_valid_i & ~bank_gnt_i;
      end
      resp_full_q <= resp_load | (resp_full_q & ~resp_pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && !req_full_q) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      strb_q  <= strb_i;
      we_q    <= we_i;
    end
    if (resp_load) begin
      rdata_q <= bank_rdata_i;
    end
  end

endmodule

// File: logic/resp_steer.sv
// Response-kind FIFO, join of the bank responses and steering to the B or R holder
`timescale 1ns/1ps

module resp_steer #(
  parameter int unsigned NumBanks = 4,
  parameter int unsigned OrderDepth = 8,
  localparam int unsigned BankBits = axi_bank_pkg::DATA_WIDTH / NumBanks,
  localparam int unsigned PtrWidth = $clog2(OrderDepth),
  localparam int unsigned CntWidth = $clog2(OrderDepth + 1)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               kind_push_i,
  input  axi_bank_pkg::resp_kind_t           kind_i,
  output logic                               kind_full_o,
  input  logic [NumBanks-1:0]                resp_valid_i,
  input  logic [NumBanks-1:0][BankBits-1:0]  resp_data_i,
  output logic [NumBanks-1:0]                resp_ready_o,
  output logic                               resp_pop_o,
  output logic                               mem_valid_b_o,
  output logic                               mem_valid_r_o,
  output axi_bank_pkg::data_t                mem_data_o
);

  axi_bank_pkg::resp_kind_t kind_mem_q [OrderDepth];
  axi_bank_pkg::resp_kind_t head_kind;
  logic [PtrWidth-1:0]      wr_ptr_q;
  logic [PtrWidth-1:0]      rd_ptr_q;
  logic [CntWidth-1:0]      count_q;
  logic                     empty;
  logic                     bypass;
  logic                     do_write;
  logic                     do_read;

  // Word is complete once every bank has answered
  assign resp_pop_o = &resp_valid_i;
  for (genvar i = 0; i < NumBanks; i++) begin : gen_join
    assign mem_data_o[i*BankBits +: BankBits] = resp_data_i[i];
    // Room for a new response in this bank's register
    assign resp_ready_o[i] = ~resp_valid_i[i] | resp_pop_o;
  end

  // Order FIFO, fall-through when empty
  assign empty       = (count_q == '0);
  assign kind_full_o = (count_q == CntWidth'(OrderDepth));
  assign head_kind   = empty ? kind_i : kind_mem_q[rd_ptr_q];
  assign bypass      = empty & kind_push_i & resp_pop_o;
  assign do_write    = kind_push_i & ~bypass;
  assign do_read     = resp_pop_o & ~empty;

  assign mem_valid_b_o = resp_pop_o & (head_kind == axi_bank_pkg::RESP_WRITE);
  assign mem_valid_r_o = resp_pop_o & (head_kind == axi_bank_pkg::RESP_READ);

  // Pointers wrap on their own; OrderDepth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_read) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_write && !do_read) begin
        count_q <= count_q + 1'b1;
      end else if (do_read && !do_write) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      kind_mem_q[wr_ptr_q] <= kind_i;
    end
  end

endmodule

// File: logic/resp_holder.sv
// Response holder FSM presenting one B or R response until the master takes it
`timescale 1ns/1ps

module resp_holder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From the request decoder
  input  logic                 trigger_i,
  output logic                 ready_o,
  input  axi_bank_pkg::id_t    id_i,
  // Joined memory response
  input  logic                 mem_valid_i,
  input  axi_bank_pkg::data_t  mem_data_i,
  // AXI response channel
  output logic                 axi_valid_o,
  input  logic                 axi_ready_i,
  output axi_bank_pkg::id_t    axi_id_o,
  output axi_bank_pkg::data_t  axi_data_o,
  output axi_bank_pkg::resp_t  axi_resp_o
);

  typedef enum logic [1:0] {
    Ready,
    Wait,
    Hold
  } state_t;

  state_t              state_d;
  state_t              state_q;
  axi_bank_pkg::data_t data_d;
  axi_bank_pkg::data_t data_q;
  axi_bank_pkg::id_t   id_d;
  axi_bank_pkg::id_t   id_q;

  always_comb begin
    // Memory valid falls through except in Hold
    case (state_q)
      Ready:   axi_valid_o = trigger_i & mem_valid_i;
      Wait:    axi_valid_o = mem_valid_i;
      Hold:    axi_valid_o = 1'b1;
      default: axi_valid_o = 1'b0;
    endcase

    data_d = data_q;
    if (mem_valid_i && (state_q == Wait || (state_q == Ready && trigger_i))) begin
      data_d = mem_data_i;
    end

    state_d = state_q;
    if (trigger_i && !mem_valid_i) begin
      state_d = Wait;
    end
    if (axi_valid_o) begin
      state_d = axi_ready_i ? Ready : Hold;
    end
  end

  assign ready_o    = (state_q == Ready);
  assign id_d       = (trigger_i && ready_o) ? id_i : id_q;
  assign axi_id_o   = id_d;
  assign axi_data_o = data_d;
  assign axi_resp_o = axi_bank_pkg::RESP_OKAY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Ready;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
    id_q   <= id_d;
  end

endmodule

// File: logic/axi_bank_bridge.sv
// Top level of the AXI bank bridge: decoder, bank ports, response steering and B/R holders
`timescale 1ns/1ps

module axi_bank_bridge #(
  parameter int unsigned NumBanks = 4,
  parameter int unsigned OrderDepth = 8,
  localparam int unsigned BankBits = axi_bank_pkg::DATA_WIDTH / NumBanks,
  localparam int unsigned BankBytes = BankBits / 8
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  output logic                                   busy_o,
  // AW channel
  input  logic                                   aw_valid_i,
  output logic                                   aw_ready_o,
  input  axi_bank_pkg::addr_t                    aw_addr_i,
  input  axi_bank_pkg::id_t                      aw_id_i,
  // W channel
  input  logic                                   w_valid_i,
  output logic                                   w_ready_o,
  input  axi_bank_pkg::data_t                    w_data_i,
  input  axi_bank_pkg::strb_t                    w_strb_i,
  // AR channel
  input  logic                                   ar_valid_i,
  output logic                                   ar_ready_o,
  input  axi_bank_pkg::addr_t                    ar_addr_i,
  input  axi_bank_pkg::id_t                      ar_id_i,
  // B channel
  output logic                                   b_valid_o,
  input  logic                                   b_ready_i,
  output axi_bank_pkg::id_t                      b_id_o,
  output axi_bank_pkg::resp_t                    b_resp_o,
  // R channel
  output logic                                   r_valid_o,
  input  logic                                   r_ready_i,
  output axi_bank_pkg::data_t                    r_data_o,
  output axi_bank_pkg::id_t                      r_id_o,
  output axi_bank_pkg::resp_t                    r_resp_o,
  output logic                                   r_last_o,
  // Memory banks
  output logic [NumBanks-1:0]                    bank_req_o,
  input  logic [NumBanks-1:0]                    bank_gnt_i,
  output axi_bank_pkg::addr_t [NumBanks-1:0]     bank_addr_o,
  output logic [NumBanks-1:0][BankBits-1:0]      bank_wdata_o,
  output logic [NumBanks-1:0][BankBytes-1:0]     bank_strb_o,
  output logic [NumBanks-1:0]                    bank_we_o,
  input  logic [NumBanks-1:0]                    bank_rvalid_i,
  input  logic [NumBanks-1:0][BankBits-1:0]      bank_rdata_i
);

  logic                                mem_req;
  logic                                mem_we;
  axi_bank_pkg::addr_t [NumBanks-1:0]  dec_addr;
  logic [NumBanks-1:0][BankBits-1:0]   dec_wdata;
  logic [NumBanks-1:0][BankBytes-1:0]  dec_strb;
  logic [NumBanks-1:0]                 req_ready;
  logic [NumBanks-1:0]                 resp_ready;
  logic [NumBanks-1:0]                 resp_valid;
  logic [NumBanks-1:0][BankBits-1:0]   resp_data;
  logic                                resp_pop;
  logic                                kind_push;
  axi_bank_pkg::resp_kind_t            kind;
  logic                                kind_full;
  logic                                b_trigger;
  logic                                r_trigger;
  axi_bank_pkg::id_t                   r_id;
  logic                                b_trig_ready;
  logic                                r_trig_ready;
  logic                                mem_valid_b;
  logic                                mem_valid_r;
  axi_bank_pkg::data_t                 mem_data;

  req_decoder #(
    .NumBanks (NumBanks)
  ) i_req_decoder (
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .aw_addr_i     (aw_addr_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_addr_i     (ar_addr_i),
    .ar_id_i       (ar_id_i),
    .req_ready_i   (req_ready),
    .resp_ready_i  (resp_ready),
    .kind_full_i   (kind_full),
    .b_ready_i     (b_trig_ready),
    .r_ready_i     (r_trig_ready),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .bank_addr_o   (dec_addr),
    .bank_wdata_o  (dec_wdata),
    .bank_strb_o   (dec_strb),
    .kind_push_o   (kind_push),
    .kind_o        (kind),
    .b_trigger_o   (b_trigger),
    .r_trigger_o   (r_trigger),
    .r_id_o        (r_id),
    .busy_o        (busy_o)
  );

  for (genvar i = 0; i < NumBanks; i++) begin : gen_banks
    bank_port #(
      .NumBanks (NumBanks)
    ) i_bank_port (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .req_valid_i    (mem_req),
      .req_ready_o    (req_ready[i]),
      .addr_i         (dec_addr[i]),
      .wdata_i        (dec_wdata[i]),
      .strb_i         (dec_strb[i]),
      .we_i           (mem_we),
      .bank_req_o     (bank_req_o[i]),
      .bank_gnt_i     (bank_gnt_i[i]),
      .bank_addr_o    (bank_addr_o[i]),
      .bank_wdata_o   (bank_wdata_o[i]),
      .bank_strb_o    (bank_strb_o[i]),
      .bank_we_o      (bank_we_o[i]),
      .bank_rvalid_i  (bank_rvalid_i[i]),
      .bank_rdata_i   (bank_rdata_i[i]),
      .resp_valid_o   (resp_valid[i]),
      .resp_data_o    (resp_data[i]),
      .resp_pop_i     (resp_pop)
    );
  end

  resp_steer #(
    .NumBanks   (NumBanks),
    .OrderDepth (OrderDepth)
  ) i_resp_steer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .kind_push_i    (kind_push),
    .kind_i         (kind),
    .kind_full_o    (kind_full),
    .resp_valid_i   (resp_valid),
    .resp_data_i    (resp_data),
    .resp_ready_o   (resp_ready),
    .resp_pop_o     (resp_pop),
    .mem_valid_b_o  (mem_valid_b),
    .mem_valid_r_o  (mem_valid_r),
    .mem_data_o     (mem_data)
  );

  // Write responses carry no data
  resp_holder i_b_holder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .trigger_i    (b_trigger),
    .ready_o      (b_trig_ready),
    .id_i         (aw_id_i),
    .mem_valid_i  (mem_valid_b),
    .mem_data_i   (mem_data),
    .axi_valid_o  (b_valid_o),
    .axi_ready_i  (b_ready_i),
    .axi_id_o     (b_id_o),
    .axi_data_o   (),
    .axi_resp_o   (b_resp_o)
  );

  resp_holder i_r_holder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .trigger_i    (r_trigger),
    .ready_o      (r_trig_ready),
    .id_i         (r_id),
    .mem_valid_i  (mem_valid_r),
    .mem_data_i   (mem_data),
    .axi_valid_o  (r_valid_o),
    .axi_ready_i  (r_ready_i),
    .axi_id_o     (r_id_o),
    .axi_data_o   (r_data_o),
    .axi_resp_o   (r_resp_o)
  );

  // Single-beat only
  assign r_last_o = 1'b1;

endmodule

// File: sim/tb_axi_bank_bridge.sv
// Testbench for the AXI bank bridge: clock, reset, banked memory model, stimulus and checks
`timescale 1ns/1ps

module tb_axi_bank_bridge;

  localparam int unsigned NumBanks = 4;
  localparam int unsigned BankBits = axi_bank_pkg::DATA_WIDTH / NumBanks;
  localparam int unsigned BankBytes = BankBits / 8;
  localparam int unsigned WordShift = $clog2(axi_bank_pkg::DATA_WIDTH / 8);
  localparam int unsigned MemWords = 2 ** (axi_bank_pkg::ADDR_WIDTH - WordShift);
  localparam int Timeout = 200;

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  logic                                 busy_o;
  logic                                 aw_valid_i;
  logic                                 aw_ready_o;
  axi_bank_pkg::addr_t                  aw_addr_i;
  axi_bank_pkg::id_t                    aw_id_i;
  logic                                 w_valid_i;
  logic                                 w_ready_o;
  axi_bank_pkg::data_t                  w_data_i;
  axi_bank_pkg::strb_t                  w_strb_i;
  logic                                 ar_valid_i;
  logic                                 ar_ready_o;
  axi_bank_pkg::addr_t                  ar_addr_i;
  axi_bank_pkg::id_t                    ar_id_i;
  logic                                 b_valid_o;
  logic                                 b_ready_i;
  axi_bank_pkg::id_t                    b_id_o;
  axi_bank_pkg::resp_t                  b_resp_o;
  logic                                 r_valid_o;
  logic                                 r_ready_i;
  axi_bank_pkg::data_t                  r_data_o;
  axi_bank_pkg::id_t                    r_id_o;
  axi_bank_pkg::resp_t                  r_resp_o;
  logic                                 r_last_o;
  logic [NumBanks-1:0]                  bank_req_o;
  logic [NumBanks-1:0]                  bank_gnt_i;
  axi_bank_pkg::addr_t [NumBanks-1:0]   bank_addr_o;
  logic [NumBanks-1:0][BankBits-1:0]    bank_wdata_o;
  logic [NumBanks-1:0][BankBytes-1:0]   bank_strb_o;
  logic [NumBanks-1:0]                  bank_we_o;
  logic [NumBanks-1:0]                  bank_rvalid_i;
  logic [NumBanks-1:0][BankBits-1:0]    bank_rdata_i;

  // Memory model state
  logic [BankBits-1:0]  mem [NumBanks][MemWords];
  logic [NumBanks-1:0]  pend_v = '0;
  logic [BankBits-1:0]  pend_d [NumBanks];
  int unsigned          gnt_cnt [NumBanks];

  // Expected responses, in issue order
  axi_bank_pkg::id_t    exp_b_id [$];
  axi_bank_pkg::id_t    exp_r_id [$];
  axi_bank_pkg::data_t  exp_r_data [$];

  // Payload seen while a response was stalled
  logic                 b_hold = 1'b0;
  axi_bank_pkg::id_t    b_hold_id;
  logic                 r_hold = 1'b0;
  axi_bank_pkg::id_t    r_hold_id;
  axi_bank_pkg::data_t  r_hold_data;

  int tests = 0;
  int errors = 0;
  int n_writes = 0;
  int n_reads = 0;
  int n_b = 0;
  int n_r = 0;
  bit timed_out = 1'b0;

  axi_bank_bridge #(
    .NumBanks   (NumBanks),
    .OrderDepth (8)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .busy_o        (busy_o),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .aw_addr_i     (aw_addr_i),
    .aw_id_i       (aw_id_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_addr_i     (ar_addr_i),
    .ar_id_i       (ar_id_i),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .b_id_o        (b_id_o),
    .b_resp_o      (b_resp_o),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_data_o      (r_data_o),
    .r_id_o        (r_id_o),
    .r_resp_o      (r_resp_o),
    .r_last_o      (r_last_o),
    .bank_req_o    (bank_req_o),
    .bank_gnt_i    (bank_gnt_i),
    .bank_addr_o   (bank_addr_o),
    .bank_wdata_o  (bank_wdata_o),
    .bank_strb_o   (bank_strb_o),
    .bank_we_o     (bank_we_o),
    .bank_rvalid_i (bank_rvalid_i),
    .bank_rdata_i  (bank_rdata_i)
  );

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  // Bank model takes granted requests on the rising edge
  always @(posedge clk_i) begin : bank_model
    int unsigned widx;
    for (int i = 0; i < NumBanks; i++) begin
      pend_v[i] = 1'b0;
      if (!rst_ni) begin
        gnt_cnt[i] = 0;
      end else if (bank_req_o[i] && bank_gnt_i[i]) begin
        // Bank i sits at its own byte offset inside the aligned word
        if (int'(bank_addr_o[i][WordShift-1:0]) != i * BankBytes) begin
          report_error($sformatf("bank %0d address %h, expected word offset %0d",
                                 i, bank_addr_o[i], i * BankBytes));
        end
        widx = int'(bank_addr_o[i][axi_bank_pkg::ADDR_WIDTH-1:WordShift]);
        if (bank_we_o[i]) begin
          for (int b = 0; b < BankBytes; b++) begin
            if (bank_strb_o[i][b]) begin
              mem[i][widx][8*b +: 8] = bank_wdata_o[i][8*b +: 8];
            end
          end
        end
        pend_v[i] = 1'b1;
        pend_d[i] = mem[i][widx];
        gnt_cnt[i] = $urandom_range(3, 0);
      end else if (bank_req_o[i] && gnt_cnt[i] != 0) begin
        gnt_cnt[i] = gnt_cnt[i] - 1;
      end
    end
  end

  // Grants, bank answers one cycle after the grant, random response stalls
  always @(negedge clk_i) begin
    for (int i = 0; i < NumBanks; i++) begin
      bank_gnt_i[i] = rst_ni && (gnt_cnt[i] == 0);
      bank_rvalid_i[i] = pend_v[i];
      bank_rdata_i[i] = pend_d[i];
    end
    b_ready_i = rst_ni && ($urandom_range(3, 0) != 0);
    r_ready_i = rst_ni && ($urandom_range(3, 0) != 0);
  end

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout: no %s within %0d cycles, giving up at %0t", what, Timeout, $time);
  endtask

  task automatic check_b_channel();
    int err0;
    axi_bank_pkg::id_t want;
    err0 = errors;
    if (b_hold && !b_valid_o) begin
      report_error("b_valid_o dropped before the handshake");
    end
    if (b_hold && b_valid_o && b_id_o != b_hold_id) begin
      report_error($sformatf("b_id_o changed under stall, %h then %h", b_hold_id, b_id_o));
    end
    b_hold = b_valid_o && !b_ready_i;
    b_hold_id = b_id_o;
    if (b_valid_o && b_ready_i) begin
      n_b++;
      tests++;
      if (exp_b_id.size() == 0) begin
        report_error("B response without a pending write");
      end else begin
        want = exp_b_id.pop_front();
        if (b_id_o != want) begin
          report_error($sformatf("b_id_o %h, expected %h", b_id_o, want));
        end
        if (b_resp_o != axi_bank_pkg::RESP_OKAY) begin
          report_error($sformatf("b_resp_o %0d, expected OKAY", b_resp_o));
        end
      end
      $display("test %0d: write id %h %s", tests, b_id_o, (errors == err0) ? "ok" : "wrong");
    end
  endtask

  task automatic check_r_channel();
    int err0;
    axi_bank_pkg::id_t want_id;
    axi_bank_pkg::data_t want_data;
    err0 = errors;
    if (r_hold && !r_valid_o) begin
      report_error("r_valid_o dropped before the handshake");
    end
    if (r_hold && r_valid_o && (r_id_o != r_hold_id || r_data_o != r_hold_data)) begin
      report_error($sformatf("R payload changed under stall, %h then %h", r_hold_data, r_data_o));
    end
    r_hold = r_valid_o && !r_ready_i;
    r_hold_id = r_id_o;
    r_hold_data = r_data_o;
    if (r_valid_o && r_ready_i) begin
      n_r++;
      tests++;
      if (exp_r_id.size() == 0) begin
        report_error("R response without a pending read");
      end else begin
        want_id = exp_r_id.pop_front();
        want_data = exp_r_data.pop_front();
        if (r_data_o != want_data) begin
          report_error($sformatf("r_data_o %h, expected %h", r_data_o, want_data));
        end
        if (r_id_o != want_id) begin
          report_error($sformatf("r_id_o %h, expected %h", r_id_o, want_id));
        end
        if (r_resp_o != axi_bank_pkg::RESP_OKAY || !r_last_o) begin
          report_error($sformatf("r_resp_o %0d r_last_o %b", r_resp_o, r_last_o));
        end
      end
      $display("test %0d: read id %h %s", tests, r_id_o, (errors == err0) ? "ok" : "wrong");
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_b_channel();
      check_r_channel();
    end
  end

  // Sampled on a rising edge, where all inputs have settled
  task automatic check_idle(input string when_s);
    int err0;
    err0 = errors;
    tests++;
    if (busy_o || b_valid_o || r_valid_o || bank_req_o != '0 ||
        aw_ready_o || w_ready_o || ar_ready_o) begin
      report_error($sformatf("not idle %s: busy %b valid %b%b req %b ready %b%b%b",
                             when_s, busy_o, b_valid_o, r_valid_o, bank_req_o,
                             aw_ready_o, w_ready_o, ar_ready_o));
    end
    $display("test %0d: idle %s %s", tests, when_s, (errors == err0) ? "ok" : "wrong");
  endtask

  // Called on a falling edge; returns on the falling edge after acceptance
  task automatic issue_write(input axi_bank_pkg::addr_t addr, input axi_bank_pkg::id_t id,
                             input axi_bank_pkg::data_t data, input axi_bank_pkg::strb_t strb);
    int waited;
    bit taken;
    exp_b_id.push_back(id);
    n_writes++;
    aw_valid_i = 1'b1;
    aw_addr_i = addr;
    aw_id_i = id;
    w_valid_i = 1'b1;
    w_data_i = data;
    w_strb_i = strb;
    waited = 0;
    taken = 1'b0;
    while (!taken && waited < Timeout) begin
      @(posedge clk_i);
      taken = aw_ready_o && w_ready_o;
      waited++;
    end
    if (!taken) begin
      report_timeout("write acceptance");
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i = 1'b0;
  endtask

  task automatic issue_read(input axi_bank_pkg::addr_t addr, input axi_bank_pkg::id_t id,
                            input axi_bank_pkg::data_t expected);
    int waited;
    bit taken;
    exp_r_id.push_back(id);
    exp_r_data.push_back(expected);
    n_reads++;
    ar_valid_i = 1'b1;
    ar_addr_i = addr;
    ar_id_i = id;
    waited = 0;
    taken = 1'b0;
    while (!taken && waited < Timeout) begin
      @(posedge clk_i);
      taken = ar_ready_o;
      waited++;
    end
    if (!taken) begin
      report_timeout("read acceptance");
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  initial begin : stimulus
    int fd;
    int n;
    int waited;
    string line;
    axi_bank_pkg::addr_t addr;
    axi_bank_pkg::id_t id;
    axi_bank_pkg::data_t data;
    axi_bank_pkg::strb_t strb;
    void'($urandom(32'hcd29));
    rst_ni = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_id_i = '0;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    bank_gnt_i = '0;
    bank_rvalid_i = '0;
    bank_rdata_i = '0;
    // Fill pattern from the byte address of each bank word
    for (int i = 0; i < NumBanks; i++) begin
      pend_d[i] = '0;
      gnt_cnt[i] = 0;
      for (int w = 0; w < MemWords; w++) begin
        mem[i][w] = BankBits'((w << WordShift) + i * BankBytes) ^ BankBits'('h5a3c);
      end
    end
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_idle("after reset");
    @(negedge clk_i);

    fd = $fopen("sim/axi_bank_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the transaction file sim/axi_bank_testdata.txt");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] == "W") begin
          n = $sscanf(line, "W %h %h %h %h", addr, id, data, strb);
          if (n == 4) begin
            issue_write(addr, id, data, strb);
          end else begin
            report_error($sformatf("malformed write line: %s", line));
          end
        end else if (line.len() > 1 && line[0] == "R") begin
          n = $sscanf(line, "R %h %h %h", addr, id, data);
          if (n == 3) begin
            issue_read(addr, id, data);
          end else begin
            report_error($sformatf("malformed read line: %s", line));
          end
        end
      end
      $fclose(fd);
    end

    // Drain the outstanding responses
    waited = 0;
    while ((exp_b_id.size() != 0 || exp_r_id.size() != 0) && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_b_id.size() != 0 || exp_r_id.size() != 0) begin
      report_timeout("outstanding B or R responses");
    end
    @(negedge clk_i);
    @(posedge clk_i);
    check_idle("at the end");

    tests++;
    if (n_b != n_writes || n_r != n_reads) begin
      report_error($sformatf("%0d B for %0d writes, %0d R for %0d reads",
                             n_b, n_writes, n_r, n_reads));
    end
    $display("test %0d: response counts B %0d R %0d", tests, n_b, n_r);

    $display("Tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: axi_bank_bridge.f
logic/axi_bank_pkg.sv
logic/req_decoder.sv
logic/bank_port.sv
logic/resp_steer.sv
logic/resp_holder.sv
logic/axi_bank_bridge.sv
sim/tb_axi_bank_bridge.sv

// File: Makefile
# Verilator build and run of the AXI bank bridge testbench

TOP = tb_axi_bank_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f axi_bank_bridge.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q '\*\*\* FAILED \*\*\*' sim.log

lint:
	verilator --lint-only --timing -Wall -f axi_bank_bridge.f --top-module $(TOP)
	verilator --lint-only -Wall logic/axi_bank_pkg.sv logic/req_decoder.sv \
		logic/bank_port.sv logic/resp_steer.sv logic/resp_holder.sv \
		logic/axi_bank_bridge.sv --top-module axi_bank_bridge

clean:
	rm -rf obj_dir sim.log

// File: sim/axi_bank_testdata.txt
# W <addr> <id> <data> <strb>     write, all fields hex
# R <addr> <id> <expected data>   read, all fields hex
W 0000 1 0011223344556677 ff
W 0008 2 8899aabbccddeeff ff
W 0010 3 0123456789abcdef ff
W 0018 4 fedcba9876543210 ff
W 0000 5 a1a2a3a4a5a6a7a8 0f
W 0008 6 1111111111111111 a5
W 0010 7 ffffffffffffffff 3c
W 0018 8 0000000000000000 81
R 0000 9 00112233a5a6a7a8
R 0008 a 119911bbcc11ee11
R 0010 b 0123ffffffffcdef
R 0018 c 00dcba9876543200
R 0013 d 0123ffffffffcdef
R 000e e 119911bbcc11ee11
W 0100 f 5555aaaa5555aaaa ff
R 0104 0 5555aaaa5555aaaa
W 0107 3 cafef00ddeadbeef f0
R 0100 1 cafef00d5555aaaa
